//--- verilog/spi_timing_pkg.sv
`default_nettype none

package spi_timing_pkg;

  // ****************************************
  // SPI frame timing, in clk cycles
  // ****************************************

  // One sclk period is two halves
  localparam int SCLK_HALF = 2;

  localparam int CS_SETUP = 2;
  localparam int CS_HOLD  = 2;

  // cs high between frames
  localparam int CS_GAP   = 2;

  // Frame bit counts
  localparam int CMD_BITS  = 12;
  localparam int READ_BITS = 8;

  // Counter widths
  localparam int SCLK_CNT_W = $clog2(SCLK_HALF + 1);
  localparam int TMR_MAX    = (CS_SETUP > CS_HOLD) ?
                              ((CS_SETUP > CS_GAP) ? CS_SETUP : CS_GAP) :
                              ((CS_HOLD > CS_GAP) ? CS_HOLD : CS_GAP);
  localparam int TMR_W      = $clog2(TMR_MAX + 1);
  localparam int BIT_CNT_W  = $clog2(((CMD_BITS > READ_BITS) ? CMD_BITS : READ_BITS) + 1);

endpackage

`default_nettype wire

//--- verilog/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

  // ****************************************
  // Command word layout
  // ****************************************

  localparam int CMD_WIDTH  = spi_timing_pkg::CMD_BITS;
  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 3;

  // Command queue
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  // Write view, bit 11 set
  typedef struct packed {
    logic                  is_write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } spi_wr_view_s;

  // Read view, low byte ignored by the peripheral
  typedef struct packed {
    logic                  is_write;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] rsvd;
  } spi_rd_view_s;

  typedef union packed {
    spi_wr_view_s wr;
    spi_rd_view_s rd;
  } spi_cmd_u;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } spi_read_s;

  // ****************************************
  // Transaction FSM states
  // ****************************************

  typedef enum logic [2:0] {
    IDLE,
    CS_LEAD,
    SHIFT_OUT,
    SHIFT_IN,
    CS_TAIL,
    GAP
  } fsm_state_e;

endpackage

`default_nettype wire

//--- verilog/spi_sclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  typedef logic [spi_timing_pkg::SCLK_CNT_W-1:0] cnt_t;

  cnt_t cnt_q;
  logic half_done;

  // Last cycle of a half period
  assign half_done = run && (cnt_q == cnt_t'(spi_timing_pkg::SCLK_HALF - 1));

  // Strobes mark the clk edge that moves sclk
  assign sclk_rise = half_done && !sclk;
  assign sclk_fall = half_done && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
      sclk  <= 1'b0;
    end
    else if (!run)
    begin
      cnt_q <= '0;
      sclk  <= 1'b0;
    end
    else if (half_done)
    begin
      cnt_q <= '0;
      sclk  <= ~sclk;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Idle clock level between shift phases
  a_sclk_idle_low : assert property (
    @(posedge clk) disable iff (!rst_n)
    !run |-> !sclk
  );

endmodule

`default_nettype wire

//--- verilog/spi_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_cmd_pkg::spi_cmd_u cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output spi_cmd_pkg::spi_cmd_u q_cmd,
  output logic                  q_vld,
  input  logic                  q_pop
);

  typedef logic [spi_cmd_pkg::PTR_W-1:0] ptr_t;
  typedef logic [spi_cmd_pkg::CNT_W-1:0] cnt_t;

  spi_cmd_pkg::spi_cmd_u mem [spi_cmd_pkg::FIFO_DEPTH];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;
  logic push;
  logic pop;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(spi_cmd_pkg::FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign cmd_rdy = (count != cnt_t'(spi_cmd_pkg::FIFO_DEPTH));
  assign q_vld   = (count != '0);
  assign q_cmd   = mem[rd_ptr];

  assign push = cmd_vld && cmd_rdy;
  assign pop  = q_pop && q_vld;

  // ****************************************
  // Pointers and occupancy
  // ****************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= cmd_in;
  end

  // FSM pops only a valid head entry
  a_pop_when_valid : assert property (
    @(posedge clk) disable iff (!rst_n)
    q_pop |-> q_vld
  );

endmodule

`default_nettype wire

//--- verilog/spi_master_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::spi_cmd_u  q_cmd,
  input  logic                   q_vld,
  output logic                   q_pop,
  output logic                   run,
  input  logic                   sclk_rise,
  input  logic                   sclk_fall,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso,
  output logic                   read_vld,
  output spi_cmd_pkg::spi_read_s read_data
);

  typedef logic [spi_timing_pkg::TMR_W-1:0]     tmr_t;
  typedef logic [spi_timing_pkg::BIT_CNT_W-1:0] bit_cnt_t;

  spi_cmd_pkg::fsm_state_e state_q;
  spi_cmd_pkg::fsm_state_e state_d;

  logic [spi_cmd_pkg::CMD_WIDTH-1:0]  q_bits;
  logic [spi_cmd_pkg::CMD_WIDTH-1:0]  tx_q;
  logic [spi_cmd_pkg::DATA_WIDTH-1:0] rx_q;
  logic                               is_wr_q;
  tmr_t                               tmr_q;
  bit_cnt_t                           bit_cnt_q;

  logic lead_done;
  logic tail_done;
  logic gap_done;
  logic out_done;
  logic in_done;
  logic rd_done;

  assign q_bits = q_cmd;

  assign lead_done = (tmr_q == tmr_t'(spi_timing_pkg::CS_SETUP - 1));
  assign tail_done = (tmr_q == tmr_t'(spi_timing_pkg::CS_HOLD - 1));
  assign gap_done  = (tmr_q == tmr_t'(spi_timing_pkg::CS_GAP - 1));

  // Frame phases end on the last sclk fall
  assign out_done = sclk_fall && (bit_cnt_q == bit_cnt_t'(spi_timing_pkg::CMD_BITS - 1));
  assign in_done  = sclk_fall && (bit_cnt_q == bit_cnt_t'(spi_timing_pkg::READ_BITS - 1));

  // First GAP cycle of a read frame
  assign rd_done = (state_q == spi_cmd_pkg::GAP) && (tmr_q == '0) && !is_wr_q;

  assign q_pop = (state_q == spi_cmd_pkg::IDLE) && q_vld;
  assign run   = (state_q == spi_cmd_pkg::SHIFT_OUT) || (state_q == spi_cmd_pkg::SHIFT_IN);

  // ****************************************
  // Next state
  // ****************************************

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      spi_cmd_pkg::IDLE:
        if (q_vld)
          state_d = spi_cmd_pkg::CS_LEAD;
      spi_cmd_pkg::CS_LEAD:
        if (lead_done)
          state_d = spi_cmd_pkg::SHIFT_OUT;
      spi_cmd_pkg::SHIFT_OUT:
        if (out_done)
          state_d = is_wr_q ? spi_cmd_pkg::CS_TAIL : spi_cmd_pkg::SHIFT_IN;
      spi_cmd_pkg::SHIFT_IN:
        if (in_done)
          state_d = spi_cmd_pkg::CS_TAIL;
      spi_cmd_pkg::CS_TAIL:
        if (tail_done)
          state_d = spi_cmd_pkg::GAP;
      spi_cmd_pkg::GAP:
        if (gap_done)
          state_d = spi_cmd_pkg::IDLE;
      default:
        state_d = spi_cmd_pkg::IDLE;
    endcase
  end

  // ****************************************
  // Control and pins
  // ****************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= spi_cmd_pkg::IDLE;
      cs        <= 1'b1;
      mosi      <= 1'b0;
      read_vld  <= 1'b0;
      is_wr_q   <= 1'b0;
      tmr_q     <= '0;
      bit_cnt_q <= '0;
    end
    else
    begin
      state_q  <= state_d;
      cs       <= (state_d == spi_cmd_pkg::IDLE) || (state_d == spi_cmd_pkg::GAP);
      read_vld <= rd_done;

      if (q_pop)
        is_wr_q <= q_cmd.wr.is_write;

      // MSB goes out during cs setup
      if (q_pop)
        mosi <= q_cmd.wr.is_write;
      else if ((state_q == spi_cmd_pkg::SHIFT_OUT) && sclk_fall)
        mosi <= out_done ? 1'b0 : tx_q[spi_cmd_pkg::CMD_WIDTH-1];

      if (state_d != state_q)
        tmr_q <= '0;
      else if ((state_q == spi_cmd_pkg::CS_LEAD) || (state_q == spi_cmd_pkg::CS_TAIL) ||
               (state_q == spi_cmd_pkg::GAP))
        tmr_q <= tmr_q + 1'b1;

      if (state_d != state_q)
        bit_cnt_q <= '0;
      else if (run && sclk_fall)
        bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  // ****************************************
  // Shift registers
  // ****************************************

  always_ff @(posedge clk)
  begin
    if (q_pop)
      tx_q <= {q_bits[spi_cmd_pkg::CMD_WIDTH-2:0], 1'b0};
    else if ((state_q == spi_cmd_pkg::SHIFT_OUT) && sclk_fall)
      tx_q <= {tx_q[spi_cmd_pkg::CMD_WIDTH-2:0], 1'b0};

    // miso is stable since the previous fall
    if ((state_q == spi_cmd_pkg::SHIFT_IN) && sclk_rise)
      rx_q <= {rx_q[spi_cmd_pkg::DATA_WIDTH-2:0], miso};

    if (rd_done)
      read_data.data <= rx_q;
  end

  // No sclk edges outside a selected frame
  a_cs_high_no_clk : assert property (
    @(posedge clk) disable iff (!rst_n)
    cs |-> !(sclk_rise || sclk_fall)
  );

endmodule

`default_nettype wire

//--- verilog/spi_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::spi_cmd_u  cmd_in,
  input  logic                   cmd_vld,
  output logic                   cmd_rdy,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   miso,
  output logic                   read_vld,
  output spi_cmd_pkg::spi_read_s read_data
);

  spi_cmd_pkg::spi_cmd_u q_cmd;
  logic                  q_vld;
  logic                  q_pop;
  logic                  run;
  logic                  sclk_rise;
  logic                  sclk_fall;

  spi_cmd_fifo fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .q_cmd   (q_cmd),
    .q_vld   (q_vld),
    .q_pop   (q_pop)
  );

  spi_sclk_gen sclk_gen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_master_fsm fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .q_cmd     (q_cmd),
    .q_vld     (q_vld),
    .q_pop     (q_pop),
    .run       (run),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

//--- verification/spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  output logic frame_err
);

  localparam int WR_RISES = spi_timing_pkg::CMD_BITS;
  localparam int RD_RISES = spi_timing_pkg::CMD_BITS + spi_timing_pkg::READ_BITS;

  logic [7:0]  regs [8];
  logic [11:0] rx_sr;
  logic [11:0] cmd_q;
  logic [7:0]  rd_byte;
  logic        first_bit;
  logic        in_frame;
  int          rises;

  // Power-up register contents
  function automatic logic [7:0] reg_init_value(input int addr);
    return 8'(8'h5c + addr * 37);
  endfunction

  initial
  begin
    miso      = 1'b0;
    frame_err = 1'b0;
    in_frame  = 1'b0;
    first_bit = 1'b0;
    rises     = 0;
    rx_sr     = '0;
    cmd_q     = '0;
    rd_byte   = '0;
    for (int i = 0; i < 8; i++)
      regs[i] = reg_init_value(i);
  end

  // ****************************************
  // Frame start, shift in, frame end
  // ****************************************

  always @(posedge sclk or posedge cs or negedge cs)
  begin
    int expected;
    if (sclk)
    begin
      if (rises == 0)
        first_bit = mosi;
      rx_sr = {rx_sr[10:0], mosi};
      rises = rises + 1;
      if (rises == WR_RISES)
      begin
        cmd_q   = rx_sr;
        rd_byte = regs[rx_sr[10:8]];
      end
    end
    else if (!cs)
    begin
      in_frame = 1'b1;
      rises    = 0;
    end
    else if (in_frame)
    begin
      in_frame = 1'b0;
      expected = first_bit ? WR_RISES : RD_RISES;
      if (rises != expected)
      begin
        $display("Frame error: %0d sclk rising edges in a %s frame, expected %0d",
                 rises, first_bit ? "write" : "read", expected);
        frame_err = 1'b1;
      end
      else if (first_bit)
        regs[cmd_q[10:8]] = cmd_q[7:0];
    end
  end

  // Read byte goes out MSB first, one bit per fall
  always @(negedge sclk)
  begin
    logic [2:0] idx;
    if (!cs && !first_bit && (rises >= WR_RISES) && (rises < RD_RISES))
    begin
      idx  = 3'(RD_RISES - 1 - rises);
      miso = rd_byte[idx];
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_spi_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_cmd;

  localparam int NUM_RANDOM     = 200;
  localparam int CYCLES_PER_CMD = 100;
  localparam int CLK_PERIOD_NS  = 10;
  localparam int TIMEOUT_NS     = NUM_RANDOM * CYCLES_PER_CMD * CLK_PERIOD_NS + 50000;

  logic                   clk;
  logic                   rst_n;
  spi_cmd_pkg::spi_cmd_u  cmd_in;
  logic                   cmd_vld;
  logic                   cmd_rdy;
  logic                   sclk;
  logic                   cs;
  logic                   mosi;
  logic                   miso;
  logic                   read_vld;
  spi_cmd_pkg::spi_read_s read_data;
  logic                   frame_err;

  logic [7:0] model_regs [8];
  logic [7:0] exp_q [$];
  int         seed;

  spi_cmd_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave_i (
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .frame_err (frame_err)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_cmd(input logic [11:0] word);
    cmd_in  = word;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
    if (word[11])
      model_regs[word[10:8]] = word[7:0];
    else
      exp_q.push_back(model_regs[word[10:8]]);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // Commands run in order so a final read closes out all earlier frames
  task automatic drain();
    send_cmd({1'b0, 3'd0, 8'h00});
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // ****************************************
  // Monitors
  // ****************************************

  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      check_value("cs at read_vld", 32'(cs), 32'd1);
      if (exp_q.size() == 0)
      begin
        $display("read_vld pulsed while no read was pending");
        $display("Regression failed");
        $fatal(1);
      end
      else
        check_value("read_data", 32'(read_data.data), 32'(exp_q.pop_front()));
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && cs)
      check_value("sclk while cs high", 32'(sclk), 32'd0);
    if (frame_err)
    begin
      $display("SPI slave model saw a malformed frame");
      $display("Regression failed");
      $fatal(1);
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $fatal(1);
  end

  // ****************************************
  // Stimulus
  // ****************************************

  initial
  begin
    int r;
    int gap;
    seed    = 32'ha753a616;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    for (int i = 0; i < 8; i++)
      model_regs[i] = 8'(8'h5c + i * 37);

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_value("cs", 32'(cs), 32'd1);
    check_value("sclk", 32'(sclk), 32'd0);
    check_value("mosi", 32'(mosi), 32'd0);
    check_value("read_vld", 32'(read_vld), 32'd0);
    check_value("cmd_rdy", 32'(cmd_rdy), 32'd1);

    // Round trip through every register
    for (int a = 0; a < 8; a++)
    begin
      r = $random(seed);
      send_cmd({1'b1, 3'(a), r[7:0]});
    end
    for (int a = 0; a < 8; a++)
      send_cmd({1'b0, 3'(a), 8'h00});
    drain();

    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      r = $random(seed);
      send_cmd(r[11:0]);
      gap = $random(seed);
      idle_cycles(gap & 7);
    end
    drain();

    // Fill the queue while a read frame is in flight
    send_cmd({1'b0, 3'd7, 8'h00});
    wait (cs == 1'b0);
    @(posedge clk);
    #1;
    for (int i = 0; i < 5; i++)
    begin
      check_value("cmd_rdy", 32'(cmd_rdy), (i < 4) ? 32'd1 : 32'd0);
      r = $random(seed);
      if (i < 4)
        send_cmd({1'b1, 3'(i), r[7:0]});
      else
        send_cmd({1'b0, 3'd1, 8'h00});
    end
    drain();

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/spi_timing_pkg.sv
verilog/spi_cmd_pkg.sv
verilog/spi_sclk_gen.sv
verilog/spi_cmd_fifo.sv
verilog/spi_master_fsm.sv
verilog/spi_cmd_top.sv
verification/spi_slave_model.sv
verification/tb_spi_cmd.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI command master testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_spi_cmd -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
